/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := enigma_tb
FILELIST  := filelist.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* bench/enigma_tb.sv */
//================================================
// directed testbench for the rotor cipher engine
// reference model, handshake and compare tasks
//================================================
`timescale 1ns/100ps
`include "enigma_defs.svh"

module enigma_tb;

  localparam int PLUG_N     = `ENIGMA_PLUG_DEPTH;
  localparam int ROT_N      = `ENIGMA_ROTOR_DEPTH;
  localparam int WAIT_LIMIT = 50;
  localparam int STREAM_N   = 40;

  logic                           clk;
  logic                           srst_n;
  logic                           cmd_req;
  enigma_host_pkg::host_cmd_t     cmd;
  logic                           cmd_ack;
  enigma_host_pkg::crypt_result_t result;

  // reference state
  enigma_rotor_pkg::sym_t m_plug [PLUG_N];
  enigma_rotor_pkg::sym_t m_rota [ROT_N];
  enigma_rotor_pkg::sym_t m_rotb [ROT_N];
  enigma_rotor_pkg::sym_t m_pos;

  enigma_rotor_pkg::sym_t         perm [ROT_N];
  enigma_rotor_pkg::sym_t         plain [STREAM_N];
  enigma_rotor_pkg::sym_t         cipher [STREAM_N];
  enigma_host_pkg::crypt_result_t results [$];

  int mismatch_errs;
  int timeout_errs;
  int protocol_errs;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  enigma_top dut0 (
    .clk(clk), .srst_n(srst_n), .cmd_req_i(cmd_req), .cmd_i(cmd),
    .cmd_ack_o(cmd_ack), .result_o(result)
  );

  // every valid output cycle is queued
  always @(negedge clk) begin
    if (srst_n && result.valid) begin
      results.push_back(result);
    end
  end

  //================================================
  // compare tasks
  //================================================
  task automatic check_sym(input string name, input enigma_rotor_pkg::sym_t got,
                           input enigma_rotor_pkg::sym_t exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("mismatch at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input string name, input enigma_host_pkg::crypt_result_t got,
                              input enigma_host_pkg::crypt_result_t exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("mismatch at %0t: %s got valid %0b code 0x%02h expected valid %0b code 0x%02h",
               $time, name, got.valid, got.code, exp.valid, exp.code);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic expect_no_result(input string what);
    if (results.size() != 0) begin
      protocol_errs++;
      $display("unexpected result on the output %s at %0t", what, $time);
      results.delete();
    end
  endtask

  //================================================
  // reference model
  //================================================
  // lowest matching entry gives its bit-0 partner
  function automatic enigma_rotor_pkg::sym_t plug_swap(input enigma_rotor_pkg::sym_t s);
    for (int k = 0; k < PLUG_N; k++) begin
      if (m_plug[k] == s) begin
        return m_plug[k ^ 1];
      end
    end
    return s;
  endfunction

  function automatic int find_entry(input logic in_b, input enigma_rotor_pkg::sym_t val);
    for (int j = 0; j < ROT_N; j++) begin
      if ((in_b ? m_rotb[j] : m_rota[j]) == val) begin
        return j;
      end
    end
    return -1;
  endfunction

  function automatic enigma_rotor_pkg::sym_t cipher_ref(input enigma_rotor_pkg::sym_t x,
                                                        input logic dec);
    enigma_rotor_pkg::sym_t    a;
    enigma_rotor_pkg::sym_t    rd;
    enigma_rotor_pkg::sym_t    r;
    enigma_rotor_pkg::sym_t    refl;
    enigma_rotor_pkg::sym_t    b;
    enigma_rotor_pkg::sym_t    c;
    logic [`ENIGMA_STEP_W-1:0] step;
    int                        idx;
    a    = plug_swap(x);
    rd   = a - m_pos;
    r    = m_rota[rd];
    refl = ~m_rotb[r];
    idx  = find_entry(1'b1, refl);
    b    = (idx < 0) ? '0 : enigma_rotor_pkg::sym_t'(idx);
    // decrypt steps on the recovered rotor A output
    step = dec ? b[`ENIGMA_STEP_W-1:0] : r[`ENIGMA_STEP_W-1:0];
    idx  = find_entry(1'b0, b);
    c    = (idx < 0) ? '0 : enigma_rotor_pkg::sym_t'(idx) + m_pos;
    m_pos = m_pos + enigma_rotor_pkg::sym_t'(step);
    return plug_swap(c);
  endfunction

  // newest entry at the highest index
  function automatic void apply_write(input enigma_host_pkg::table_sel_e sel,
                                      input enigma_rotor_pkg::sym_t d);
    case (sel)
      enigma_host_pkg::sel_plug: begin
        for (int i = 0; i < PLUG_N - 1; i++) begin
          m_plug[i] = m_plug[i+1];
        end
        m_plug[PLUG_N-1] = d;
      end
      enigma_host_pkg::sel_rotor_a: begin
        for (int i = 0; i < ROT_N - 1; i++) begin
          m_rota[i] = m_rota[i+1];
        end
        m_rota[ROT_N-1] = d;
      end
      enigma_host_pkg::sel_rotor_b: begin
        for (int i = 0; i < ROT_N - 1; i++) begin
          m_rotb[i] = m_rotb[i+1];
        end
        m_rotb[ROT_N-1] = d;
      end
      default: begin
      end
    endcase
    m_pos = '0;
  endfunction

  //================================================
  // host side tasks
  //================================================
  task automatic send_cmd(input enigma_host_pkg::host_cmd_t c);
    int n;
    @(negedge clk);
    check_bit("cmd_ack_o", cmd_ack, 1'b0);
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd     <= c;
    n = 0;
    @(negedge clk);
    while (!cmd_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ack) begin
      timeout_errs++;
      $display("timeout at %0t: ack never rose for the command", $time);
    end
    // ack holds while req is held
    repeat (2) begin
      @(negedge clk);
      check_bit("cmd_ack_o", cmd_ack, 1'b1);
    end
    @(posedge clk);
    cmd_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (cmd_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (cmd_ack) begin
      timeout_errs++;
      $display("timeout at %0t: ack never fell after req dropped", $time);
    end
  endtask

  task automatic wait_result(output enigma_host_pkg::crypt_result_t res);
    int n;
    n   = 0;
    res = '0;
    while (results.size() == 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (results.size() == 0) begin
      timeout_errs++;
      $display("timeout at %0t: no result for a crypt command", $time);
    end else begin
      res = results.pop_front();
    end
  endtask

  task automatic run_crypt(input enigma_rotor_pkg::sym_t s, input logic dec,
                           output enigma_rotor_pkg::sym_t code);
    enigma_host_pkg::host_cmd_t     c;
    enigma_host_pkg::crypt_result_t res;
    enigma_host_pkg::crypt_result_t exp;
    expect_no_result("before a crypt command");
    exp.valid   = 1'b1;
    exp.code    = cipher_ref(s, dec);
    c.op        = enigma_host_pkg::op_crypt;
    c.table_sel = enigma_host_pkg::sel_plug;
    c.decrypt   = dec;
    c.symbol    = s;
    send_cmd(c);
    wait_result(res);
    check_result("result_o", res, exp);
    check_sym("position", dut0.u_pipeline.position_q, m_pos);
    code = res.code;
  endtask

  // writes the first count entries of perm
  task automatic load_table(input enigma_host_pkg::table_sel_e sel, input int count);
    enigma_host_pkg::host_cmd_t c;
    for (int i = 0; i < count; i++) begin
      c.op        = enigma_host_pkg::op_load;
      c.table_sel = sel;
      c.decrypt   = 1'b0;
      c.symbol    = perm[i];
      send_cmd(c);
      apply_write(sel, perm[i]);
    end
    repeat (8) @(posedge clk);
    expect_no_result("after a table load");
  endtask

  task automatic shuffle_perm();
    enigma_rotor_pkg::sym_t t;
    int                     j;
    for (int i = 0; i < ROT_N; i++) begin
      perm[i] = enigma_rotor_pkg::sym_t'(i);
    end
    for (int i = ROT_N - 1; i > 0; i--) begin
      j       = int'($urandom % (i + 1));
      t       = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
  endtask

  //================================================
  // directed tests
  //================================================
  task automatic reset_checks();
    enigma_rotor_pkg::sym_t code;
    repeat (4) begin
      @(negedge clk);
      check_bit("cmd_ack_o", cmd_ack, 1'b0);
      check_bit("result_o.valid", result.valid, 1'b0);
    end
    // all-zero tables
    run_crypt(6'h00, 1'b0, code);
    run_crypt(6'h15, 1'b0, code);
  endtask

  task automatic handshake_checks();
    enigma_rotor_pkg::sym_t code;
    perm[0] = 6'h2a;
    load_table(enigma_host_pkg::sel_plug, 1);
    run_crypt(6'h2a, 1'b0, code);
    repeat (8) @(posedge clk);
    expect_no_result("after the single crypt result");
  endtask

  task automatic encrypt_stream();
    shuffle_perm();
    load_table(enigma_host_pkg::sel_plug, PLUG_N);
    shuffle_perm();
    load_table(enigma_host_pkg::sel_rotor_a, ROT_N);
    shuffle_perm();
    load_table(enigma_host_pkg::sel_rotor_b, ROT_N);
    for (int i = 0; i < STREAM_N; i++) begin
      plain[i] = enigma_rotor_pkg::sym_t'($urandom);
      run_crypt(plain[i], 1'b0, cipher[i]);
    end
  endtask

  task automatic reload_and_decrypt();
    enigma_rotor_pkg::sym_t back;
    for (int i = 0; i < PLUG_N; i++) begin
      perm[i] = m_plug[i];
    end
    load_table(enigma_host_pkg::sel_plug, PLUG_N);
    check_sym("position", dut0.u_pipeline.position_q, 6'h00);
    for (int i = 0; i < STREAM_N; i++) begin
      run_crypt(cipher[i], 1'b1, back);
      check_sym("plaintext", back, plain[i]);
    end
  endtask

  task automatic plug_pass_through();
    enigma_rotor_pkg::sym_t code;
    enigma_rotor_pkg::sym_t s;
    int                     absent;
    absent = 0;
    for (int v = 0; v < ROT_N && absent < 4; v++) begin
      s = enigma_rotor_pkg::sym_t'(v);
      if (plug_swap(s) == s) begin
        run_crypt(s, 1'b0, code);
        absent++;
      end
    end
    // swapped pairs on both sides of a pair
    for (int k = 0; k < 4; k++) begin
      run_crypt(m_plug[k], 1'b0, code);
    end
  endtask

  initial begin
    srst_n        = 1'b0;
    cmd_req       = 1'b0;
    cmd           = '0;
    mismatch_errs = 0;
    timeout_errs  = 0;
    protocol_errs = 0;
    m_pos         = '0;
    for (int i = 0; i < PLUG_N; i++) begin
      m_plug[i] = '0;
    end
    for (int i = 0; i < ROT_N; i++) begin
      m_rota[i] = '0;
      m_rotb[i] = '0;
    end
    void'($urandom(46204));
    repeat (2) @(posedge clk);
    srst_n <= 1'b1;

    reset_checks();
    handshake_checks();
    encrypt_stream();
    reload_and_decrypt();
    plug_pass_through();

    repeat (8) @(posedge clk);
    expect_no_result("at the end of the run");
    $display("errors: mismatch %0d, timeout %0d, protocol %0d",
             mismatch_errs, timeout_errs, protocol_errs);
    if (mismatch_errs + timeout_errs + protocol_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/enigma_rotor_pkg.sv
hw/enigma_host_pkg.sv
hw/enigma_host_if.sv
hw/enigma_plugboard.sv
hw/enigma_rotor_a.sv
hw/enigma_rotor_b.sv
hw/enigma_pipeline.sv
hw/enigma_top.sv
bench/enigma_tb.sv

/* hw/enigma_defs.svh */
//================================================
// symbol width, table depths and stepping field
// width of the rotor cipher engine
//================================================
`ifndef ENIGMA_DEFS_SVH
`define ENIGMA_DEFS_SVH

// one cipher symbol
`define ENIGMA_SYM_W        6

// entries per rotor table
`define ENIGMA_ROTOR_DEPTH  64

// plug board holds 16 swap pairs
`define ENIGMA_PLUG_DEPTH   32

// low bits of a rotor output that step rotor A
`define ENIGMA_STEP_W       2

`endif

/* hw/enigma_host_if.sv */
//================================================
// four-phase command acceptor that decodes each
// command into a table write or a symbol issue
//================================================
`timescale 1ns/100ps

module enigma_host_if (
  input  logic                         clk,
  input  logic                         srst_n,
  input  logic                         cmd_req_i,
  input  enigma_host_pkg::host_cmd_t   cmd_i,
  output logic                         cmd_ack_o,
  output enigma_host_pkg::table_wr_t   table_wr_o,
  output enigma_rotor_pkg::sym_issue_t sym_issue_o
);

  logic                   ack_q;
  logic                   accept;
  logic                   is_load;
  logic                   wr_plug_q;
  logic                   wr_rota_q;
  logic                   wr_rotb_q;
  logic                   issue_q;
  logic                   decrypt_q;
  enigma_rotor_pkg::sym_t data_q;

  // new command only when ack is back low
  assign accept  = cmd_req_i && !ack_q;
  assign is_load = (cmd_i.op == enigma_host_pkg::op_load);

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      ack_q <= 1'b0;
    end else if (accept) begin
      ack_q <= 1'b1;
    end else if (!cmd_req_i) begin
      ack_q <= 1'b0;
    end
  end

  // single-cycle strobes after acceptance
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      wr_plug_q <= 1'b0;
      wr_rota_q <= 1'b0;
      wr_rotb_q <= 1'b0;
      issue_q   <= 1'b0;
    end else begin
      wr_plug_q <= accept && is_load && (cmd_i.table_sel == enigma_host_pkg::sel_plug);
      wr_rota_q <= accept && is_load && (cmd_i.table_sel == enigma_host_pkg::sel_rotor_a);
      wr_rotb_q <= accept && is_load && (cmd_i.table_sel == enigma_host_pkg::sel_rotor_b);
      issue_q   <= accept && !is_load;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_q    <= cmd_i.symbol;
      decrypt_q <= cmd_i.decrypt;
    end
  end

  assign cmd_ack_o   = ack_q;
  assign table_wr_o  = '{wr_plug: wr_plug_q, wr_rota: wr_rota_q, wr_rotb: wr_rotb_q,
                         data: data_q};
  assign sym_issue_o = '{valid: issue_q, decrypt: decrypt_q, sym: data_q};

  // host starts a command only once ack is low
  a_req_after_ack : assert property (@(posedge clk) disable iff (!srst_n)
    $rose(cmd_req_i) |-> !ack_q);

endmodule

/* hw/enigma_host_pkg.sv */
//================================================
// host side types: command, table write strobe
// and enciphered result
//================================================
package enigma_host_pkg;

  typedef enum logic [1:0] {
    sel_plug    = 2'd0,
    sel_rotor_a = 2'd1,
    sel_rotor_b = 2'd2
  } table_sel_e;

  typedef enum logic {
    op_load  = 1'b0,
    op_crypt = 1'b1
  } cmd_op_e;

  // symbol doubles as table data on a load
  typedef struct packed {
    cmd_op_e                op;
    table_sel_e             table_sel;
    logic                   decrypt;
    enigma_rotor_pkg::sym_t symbol;
  } host_cmd_t;

  typedef struct packed {
    logic                   wr_plug;
    logic                   wr_rota;
    logic                   wr_rotb;
    enigma_rotor_pkg::sym_t data;
  } table_wr_t;

  typedef struct packed {
    logic                   valid;
    enigma_rotor_pkg::sym_t code;
  } crypt_result_t;

endpackage

/* hw/enigma_pipeline.sv */
//================================================
// stage registers, valid chain and rotor A
// position counter
//================================================
`timescale 1ns/100ps
`include "enigma_defs.svh"

module enigma_pipeline (
  input  logic                           clk,
  input  logic                           srst_n,
  input  enigma_rotor_pkg::sym_issue_t   sym_issue_i,
  input  enigma_host_pkg::table_wr_t     table_wr_i,
  input  enigma_rotor_pkg::sym_t         plug_fwd_i,
  input  enigma_rotor_pkg::sym_t         plug_ret_i,
  input  enigma_rotor_pkg::sym_step_u    rota_fwd_i,
  input  enigma_rotor_pkg::sym_t         rota_inv_i,
  input  enigma_rotor_pkg::sym_step_u    rotb_inv_i,
  output enigma_rotor_pkg::sym_t         plug_fwd_addr_o,
  output enigma_rotor_pkg::sym_t         plug_ret_addr_o,
  output enigma_rotor_pkg::sym_t         rota_fwd_addr_o,
  output enigma_rotor_pkg::sym_t         rota_inv_addr_o,
  output enigma_rotor_pkg::sym_t         rotb_addr_o,
  output enigma_rotor_pkg::sym_t         position_o,
  output enigma_rotor_pkg::sym_t         inv_position_o,
  output enigma_host_pkg::crypt_result_t result_o
);

  enigma_rotor_pkg::stage_t         s0_q;
  enigma_rotor_pkg::stage_t         s1_q;
  enigma_rotor_pkg::stage_t         s2_q;
  enigma_rotor_pkg::stage_t         s3_q;
  enigma_rotor_pkg::sym_t           s2_pos_q;
  enigma_rotor_pkg::sym_t           position_q;
  enigma_host_pkg::crypt_result_t   result_q;
  logic [`ENIGMA_STEP_W-1:0]        step;
  logic                             wr_any;

  //================================================
  // stage chain
  //================================================
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      s0_q.valid     <= 1'b0;
      s1_q.valid     <= 1'b0;
      s2_q.valid     <= 1'b0;
      s3_q.valid     <= 1'b0;
      result_q.valid <= 1'b0;
    end else begin
      s0_q           <= '{valid: sym_issue_i.valid, decrypt: sym_issue_i.decrypt,
                          sym: sym_issue_i.sym};
      s1_q           <= '{valid: s0_q.valid, decrypt: s0_q.decrypt, sym: plug_fwd_i};
      s2_q           <= '{valid: s1_q.valid, decrypt: s1_q.decrypt, sym: rotb_inv_i.sym};
      s2_pos_q       <= position_q;
      s3_q           <= '{valid: s2_q.valid, decrypt: s2_q.decrypt, sym: rota_inv_i};
      result_q.valid <= s3_q.valid;
      result_q.code  <= plug_ret_i;
    end
  end

  //================================================
  // rotor A position
  //================================================
  assign wr_any = table_wr_i.wr_plug || table_wr_i.wr_rota || table_wr_i.wr_rotb;

  // decrypt steps on inverse rotor B, which equals the encrypt-side rotor A output
  assign step = s1_q.decrypt ? rotb_inv_i.split.step : rota_fwd_i.split.step;

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      position_q <= '0;
    end else if (wr_any) begin
      position_q <= '0;
    end else if (s1_q.valid) begin
      position_q <= position_q + {{(`ENIGMA_SYM_W-`ENIGMA_STEP_W){1'b0}}, step};
    end
  end

  // lookup addresses
  assign plug_fwd_addr_o = s0_q.sym;
  assign rota_fwd_addr_o = s1_q.sym;
  assign rotb_addr_o     = rota_fwd_i.sym;
  assign rota_inv_addr_o = s2_q.sym;
  assign plug_ret_addr_o = s3_q.sym;
  assign position_o      = position_q;
  assign inv_position_o  = s2_pos_q;
  assign result_o        = result_q;

  // a write clearing the position would swallow this symbol's step
  a_no_wr_on_step : assert property (@(posedge clk) disable iff (!srst_n)
    wr_any |-> !s1_q.valid);

endmodule

/* hw/enigma_plugboard.sv */
//================================================
// plug board store, forward and return swaps
//================================================
`timescale 1ns/100ps
`include "enigma_defs.svh"

module enigma_plugboard (
  input  logic                       clk,
  input  logic                       srst_n,
  input  enigma_host_pkg::table_wr_t table_wr_i,
  input  enigma_rotor_pkg::sym_t     fwd_sym_i,
  input  enigma_rotor_pkg::sym_t     ret_sym_i,
  output enigma_rotor_pkg::sym_t     fwd_sym_o,
  output enigma_rotor_pkg::sym_t     ret_sym_o
);

  localparam int DEPTH = `ENIGMA_PLUG_DEPTH;

  enigma_rotor_pkg::sym_t table_q [DEPTH];

  // new entry lands at the top, older ones move down
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        table_q[i] <= '0;
      end
    end else if (table_wr_i.wr_plug) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        table_q[i] <= table_q[i+1];
      end
      table_q[DEPTH-1] <= table_wr_i.data;
    end
  end

  // partner of entry k sits at k^1, lowest match wins
  function automatic enigma_rotor_pkg::sym_t swap(input enigma_rotor_pkg::sym_t sym);
    enigma_rotor_pkg::sym_t res;
    res = sym;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      if (table_q[k] == sym) begin
        res = table_q[k ^ 1];
      end
    end
    return res;
  endfunction

  always_comb begin
    fwd_sym_o = swap(fwd_sym_i);
    ret_sym_o = swap(ret_sym_i);
  end

endmodule

/* hw/enigma_rotor_a.sv */
//================================================
// rotor A store, offset forward lookup and
// inverse search
//================================================
`timescale 1ns/100ps
`include "enigma_defs.svh"

module enigma_rotor_a (
  input  logic                        clk,
  input  logic                        srst_n,
  input  enigma_host_pkg::table_wr_t  table_wr_i,
  input  enigma_rotor_pkg::sym_t      position_i,
  input  enigma_rotor_pkg::sym_t      fwd_sym_i,
  input  enigma_rotor_pkg::sym_t      inv_sym_i,
  input  enigma_rotor_pkg::sym_t      inv_position_i,
  output enigma_rotor_pkg::sym_step_u fwd_sym_o,
  output enigma_rotor_pkg::sym_t      inv_sym_o
);

  localparam int DEPTH = `ENIGMA_ROTOR_DEPTH;

  enigma_rotor_pkg::sym_t table_q [DEPTH];
  enigma_rotor_pkg::sym_t rd_idx;
  enigma_rotor_pkg::sym_t inv_idx;
  logic                   inv_found;

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        table_q[i] <= '0;
      end
    end else if (table_wr_i.wr_rota) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        table_q[i] <= table_q[i+1];
      end
      table_q[DEPTH-1] <= table_wr_i.data;
    end
  end

  // wraps modulo 64
  assign rd_idx        = fwd_sym_i - position_i;
  assign fwd_sym_o.sym = table_q[rd_idx];

  always_comb begin
    inv_idx   = '0;
    inv_found = 1'b0;
    for (int j = DEPTH - 1; j >= 0; j--) begin
      if (table_q[j] == inv_sym_i) begin
        inv_idx   = enigma_rotor_pkg::sym_t'(j);
        inv_found = 1'b1;
      end
    end
  end

  // undo the offset of the symbol's own stage
  assign inv_sym_o = inv_found ? (inv_idx + inv_position_i) : '0;

endmodule

/* hw/enigma_rotor_b.sv */
//================================================
// rotor B store, forward lookup, reflector and
// inverse search
//================================================
`timescale 1ns/100ps
`include "enigma_defs.svh"

module enigma_rotor_b (
  input  logic                        clk,
  input  logic                        srst_n,
  input  enigma_host_pkg::table_wr_t  table_wr_i,
  input  enigma_rotor_pkg::sym_t      sym_i,
  output enigma_rotor_pkg::sym_step_u inv_sym_o
);

  localparam int DEPTH = `ENIGMA_ROTOR_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  enigma_rotor_pkg::sym_t table_q [DEPTH];
  logic [CNT_W-1:0]       wr_cnt_q;
  enigma_rotor_pkg::sym_t reflected;
  enigma_rotor_pkg::sym_t inv_idx;
  logic                   inv_found;

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        table_q[i] <= '0;
      end
    end else if (table_wr_i.wr_rotb) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        table_q[i] <= table_q[i+1];
      end
      table_q[DEPTH-1] <= table_wr_i.data;
    end
  end

  // saturates once every entry has been written
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      wr_cnt_q <= '0;
    end else if (table_wr_i.wr_rotb && (wr_cnt_q != CNT_W'(DEPTH))) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
    end
  end

  // reflector is a plain inversion
  assign reflected = ~table_q[sym_i];

  always_comb begin
    inv_idx   = '0;
    inv_found = 1'b0;
    for (int j = DEPTH - 1; j >= 0; j--) begin
      if (table_q[j] == reflected) begin
        inv_idx   = enigma_rotor_pkg::sym_t'(j);
        inv_found = 1'b1;
      end
    end
  end

  assign inv_sym_o.sym = inv_idx;

  a_inv_hit : assert property (@(posedge clk) disable iff (!srst_n)
    (wr_cnt_q == CNT_W'(DEPTH)) |-> inv_found);

endmodule

/* hw/enigma_rotor_pkg.sv */
//================================================
// symbol, stepping view of a rotor output and
// pipeline stage types
//================================================
`include "enigma_defs.svh"

package enigma_rotor_pkg;

  typedef logic [`ENIGMA_SYM_W-1:0] sym_t;

  typedef struct packed {
    logic [`ENIGMA_SYM_W-`ENIGMA_STEP_W-1:0] upper;
    logic [`ENIGMA_STEP_W-1:0]               step;
  } sym_split_t;

  // same word read as a symbol or as a step amount
  typedef union packed {
    sym_t       sym;
    sym_split_t split;
  } sym_step_u;

  typedef struct packed {
    logic valid;
    logic decrypt;
    sym_t sym;
  } sym_issue_t;

  typedef struct packed {
    logic valid;
    logic decrypt;
    sym_t sym;
  } stage_t;

endpackage

/* hw/enigma_top.sv */
//================================================
// rotor cipher engine top level
//================================================
`timescale 1ns/100ps

module enigma_top (
  input  logic                           clk,
  input  logic                           srst_n,
  input  logic                           cmd_req_i,
  input  enigma_host_pkg::host_cmd_t     cmd_i,
  output logic                           cmd_ack_o,
  output enigma_host_pkg::crypt_result_t result_o
);

  enigma_host_pkg::table_wr_t   table_wr;
  enigma_rotor_pkg::sym_issue_t sym_issue;
  enigma_rotor_pkg::sym_t       plug_fwd_addr;
  enigma_rotor_pkg::sym_t       plug_ret_addr;
  enigma_rotor_pkg::sym_t       rota_fwd_addr;
  enigma_rotor_pkg::sym_t       rota_inv_addr;
  enigma_rotor_pkg::sym_t       rotb_addr;
  enigma_rotor_pkg::sym_t       position;
  enigma_rotor_pkg::sym_t       inv_position;
  enigma_rotor_pkg::sym_t       plug_fwd;
  enigma_rotor_pkg::sym_t       plug_ret;
  enigma_rotor_pkg::sym_t       rota_inv;
  enigma_rotor_pkg::sym_step_u  rota_fwd;
  enigma_rotor_pkg::sym_step_u  rotb_inv;

  enigma_host_if u_host_if (
    .clk(clk), .srst_n(srst_n), .cmd_req_i(cmd_req_i), .cmd_i(cmd_i),
    .cmd_ack_o(cmd_ack_o), .table_wr_o(table_wr), .sym_issue_o(sym_issue)
  );

  enigma_plugboard u_plugboard (
    .clk(clk), .srst_n(srst_n), .table_wr_i(table_wr),
    .fwd_sym_i(plug_fwd_addr), .ret_sym_i(plug_ret_addr),
    .fwd_sym_o(plug_fwd), .ret_sym_o(plug_ret)
  );

  enigma_rotor_a u_rotor_a (
    .clk(clk), .srst_n(srst_n), .table_wr_i(table_wr), .position_i(position),
    .fwd_sym_i(rota_fwd_addr), .inv_sym_i(rota_inv_addr), .inv_position_i(inv_position),
    .fwd_sym_o(rota_fwd), .inv_sym_o(rota_inv)
  );

  enigma_rotor_b u_rotor_b (
    .clk(clk), .srst_n(srst_n), .table_wr_i(table_wr),
    .sym_i(rotb_addr), .inv_sym_o(rotb_inv)
  );

  enigma_pipeline u_pipeline (
    .clk(clk), .srst_n(srst_n), .sym_issue_i(sym_issue), .table_wr_i(table_wr),
    .plug_fwd_i(plug_fwd), .plug_ret_i(plug_ret), .rota_fwd_i(rota_fwd),
    .rota_inv_i(rota_inv), .rotb_inv_i(rotb_inv),
    .plug_fwd_addr_o(plug_fwd_addr), .plug_ret_addr_o(plug_ret_addr),
    .rota_fwd_addr_o(rota_fwd_addr), .rota_inv_addr_o(rota_inv_addr),
    .rotb_addr_o(rotb_addr), .position_o(position), .inv_position_o(inv_position),
    .result_o(result_o)
  );

endmodule
